// File: ps2_key_tracker.f
+incdir+hdl
hdl/ps2_key_pkg.sv
hdl/ps2_frame_receiver.sv
hdl/scan_code_decoder.sv
hdl/key_state_tracker.sv
hdl/ps2_key_tracker.sv
tests/ps2_key_tracker_properties.sv
tests/ps2_key_tracker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the PS/2 key tracker testbench with Verilator
# exits non-zero when the build fails, the run aborts or the log shows a failure

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=ps2_key_tracker_sim
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module ps2_key_tracker_tb \
  -f ps2_key_tracker.f \
  -Mdir "${build_dir}" -o "${sim_name}"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./${build_dir}/${sim_name}" 2>&1 | tee "${log_file}"
sim_status=${PIPESTATUS[0]}
if [ "${sim_status}" -ne 0 ]; then
  echo "simulation stopped with status ${sim_status}"
  exit 1
fi

if grep -q "Test failed" "${log_file}"; then
  exit 1
fi

if ! grep -q "Test passed" "${log_file}"; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0

// File: tests/ps2_key_tracker_tb.sv
// testbench for the PS/2 key tracker
// frames change only on falling system clock edges
// ps2 clock half period is 20 system cycles
// each table row is checked 60 cycles after its last frame
// expected values come from the table and from a reference model of the rules
`timescale 1ns/1ps
`include "ps2_key_settings.svh"

module ps2_key_tracker_tb;

  import ps2_key_pkg::*;

  localparam int half_period = 20;
  localparam int row_count   = 14;
  localparam int margin      = 60;
  localparam int max_gap     = 70;
  // bad_index value for a row with no corrupted frame
  localparam int no_bad      = 7;

  // byte 0 is sent first
  // two bits of pulse count per key
  typedef struct packed {
    logic [0:3][7:0]            bytes;
    logic [2:0]                 count;
    logic [2:0]                 bad_index;
    logic                       do_reset;
    key_vector_t                exp_held;
    logic [`KEY_COUNT-1:0][1:0] exp_pulses;
  } row_t;

  // make codes by key position, a w s e d f t g y h u j
  localparam logic [7:0] key_codes [`KEY_COUNT] = '{
    8'h1C, 8'h1D, 8'h1B, 8'h24, 8'h23, 8'h2B,
    8'h2C, 8'h34, 8'h35, 8'h33, 8'h3C, 8'h3B
  };

  logic        clock;
  logic        reset;
  logic        ps2_clock;
  logic        ps2_data;
  key_vector_t held;
  key_vector_t pressed;

  row_t        table_rows [row_count];
  // running pulse totals seen on the DUT and their values at row start
  int          pulse_count [`KEY_COUNT];
  int          pulse_start [`KEY_COUNT];
  // reference model state
  int          model_pulses [`KEY_COUNT];
  key_vector_t model_held;
  logic        model_ext;
  logic        model_brk;
  int          held_errors;
  int          pulse_errors;
  int          cycle_count;
  int          cycle_limit;

  ps2_key_tracker dut_i (
    .clock     (clock),
    .reset     (reset),
    .ps2_clock (ps2_clock),
    .ps2_data  (ps2_data),
    .held      (held),
    .pressed   (pressed)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // run limit
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout, run went past %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // count pulses on the falling edge where pressed is stable
  always @(negedge clock) begin
    for (int k = 0; k < `KEY_COUNT; k++) begin
      if (pressed[k]) begin
        pulse_count[k] = pulse_count[k] + 1;
      end
    end
  end

  function automatic row_t make_row(logic [0:3][7:0] bytes, int count, int bad_index,
                                    logic do_reset, key_vector_t exp_held,
                                    logic [`KEY_COUNT-1:0][1:0] exp_pulses);
    row_t row;
    row.bytes      = bytes;
    row.count      = 3'(count);
    row.bad_index  = 3'(bad_index);
    row.do_reset   = do_reset;
    row.exp_held   = exp_held;
    row.exp_pulses = exp_pulses;
    return row;
  endfunction

  task automatic fill_table();
    table_rows[0]  = make_row(32'h1C000000, 1, no_bad, 1'b0, 12'h001, 24'h000001);
    // typematic repeats
    table_rows[1]  = make_row(32'h1C1C1C00, 3, no_bad, 1'b0, 12'h001, 24'h000000);
    table_rows[2]  = make_row(32'h1D1B0000, 2, no_bad, 1'b0, 12'h007, 24'h000014);
    // release w only
    table_rows[3]  = make_row(32'hF01D0000, 2, no_bad, 1'b0, 12'h005, 24'h000000);
    table_rows[4]  = make_row(32'h24232B00, 3, no_bad, 1'b0, 12'h03D, 24'h000540);
    // a released, then an extended make of 1C must leave it up
    table_rows[5]  = make_row(32'hF01CE01C, 4, no_bad, 1'b0, 12'h03C, 24'h000000);
    // a down again, then an extended break of 1C must leave it down
    table_rows[6]  = make_row(32'h1CE0F01C, 4, no_bad, 1'b0, 12'h03D, 24'h000001);
    // unknown codes
    table_rows[7]  = make_row(32'h775A0000, 2, no_bad, 1'b0, 12'h03D, 24'h000000);
    // t sent with bad parity and g still gets through
    table_rows[8]  = make_row(32'h2C340000, 2, 0, 1'b0, 12'h0BD, 24'h004000);
    table_rows[9]  = make_row(32'hF01C1C00, 3, no_bad, 1'b0, 12'h0BD, 24'h000001);
    // y down, up, down
    table_rows[10] = make_row(32'h35F03535, 4, no_bad, 1'b0, 12'h1BD, 24'h020000);
    table_rows[11] = make_row(32'h333C3B00, 3, no_bad, 1'b0, 12'hFBD, 24'h540000);
    table_rows[12] = make_row(32'h00000000, 0, no_bad, 1'b1, 12'h000, 24'h000000);
    table_rows[13] = make_row(32'hF01B1D00, 3, no_bad, 1'b0, 12'h002, 24'h000004);
  endtask

  // twice the frame cycles of the whole table plus margins
  function automatic int cycle_budget();
    int total;
    total = 16;
    for (int r = 0; r < row_count; r++) begin
      total += table_rows[r].do_reset ? 16 : 0;
      total += int'(table_rows[r].count) *
               (max_gap + 2 * half_period * `PS2_FRAME_BITS);
      total += margin;
    end
    return 2 * total;
  endfunction

  // start, data lsb first, odd parity, stop
  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [`PS2_FRAME_BITS-1:0] frame;
    logic                       parity;
    parity = ~^data;
    if (bad_parity) begin
      parity = ~parity;
    end
    frame = {1'b1, parity, data, 1'b0};
    for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
      ps2_data = frame[i];
      repeat (half_period) @(negedge clock);
      ps2_clock = 1'b0;
      repeat (half_period) @(negedge clock);
      ps2_clock = 1'b1;
    end
  endtask

  // reference model step for one received byte
  task automatic model_apply(input logic [7:0] code, input logic corrupt);
    if (!corrupt) begin
      if (code == 8'hE0) begin
        model_ext = 1'b1;
      end else if (code == 8'hF0) begin
        model_brk = 1'b1;
      end else begin
        for (int k = 0; k < `KEY_COUNT; k++) begin
          if (!model_ext && code == key_codes[k]) begin
            if (model_brk) begin
              model_held[k] = 1'b0;
            end else begin
              if (!model_held[k]) begin
                model_pulses[k]++;
              end
              model_held[k] = 1'b1;
            end
          end
        end
        model_ext = 1'b0;
        model_brk = 1'b0;
      end
    end
  endtask

  task automatic check_row(input int r);
    int got;
    assert (held == table_rows[r].exp_held) else begin
      held_errors++;
      $display("[FAIL] %0t row %0d held %h, expected %h", $time, r, held,
               table_rows[r].exp_held);
    end
    assert (model_held == table_rows[r].exp_held) else begin
      held_errors++;
      $display("[FAIL] %0t row %0d model held %h, table %h", $time, r, model_held,
               table_rows[r].exp_held);
    end
    for (int k = 0; k < `KEY_COUNT; k++) begin
      got = pulse_count[k] - pulse_start[k];
      assert (got == int'(table_rows[r].exp_pulses[k])) else begin
        pulse_errors++;
        $display("[FAIL] %0t row %0d key %0d pulses %0d, expected %0d", $time, r, k, got,
                 table_rows[r].exp_pulses[k]);
      end
      assert (model_pulses[k] == int'(table_rows[r].exp_pulses[k])) else begin
        pulse_errors++;
        $display("[FAIL] %0t row %0d key %0d model pulses %0d, table %0d", $time, r, k,
                 model_pulses[k], table_rows[r].exp_pulses[k]);
      end
    end
  endtask

  task automatic run_row(input int r);
    row_t row;
    int   gap;
    row = table_rows[r];
    for (int k = 0; k < `KEY_COUNT; k++) begin
      pulse_start[k]  = pulse_count[k];
      model_pulses[k] = 0;
    end
    // mid run reset clears the model as well
    if (row.do_reset) begin
      reset = 1'b0;
      repeat (16) @(negedge clock);
      reset = 1'b1;
      model_held = '0;
      model_ext  = 1'b0;
      model_brk  = 1'b0;
    end
    for (int b = 0; b < int'(row.count); b++) begin
      gap = 20 + int'($urandom % 40);
      repeat (gap) @(negedge clock);
      send_frame(row.bytes[b], b == int'(row.bad_index));
      model_apply(row.bytes[b], b == int'(row.bad_index));
    end
    repeat (margin) @(negedge clock);
    check_row(r);
  endtask

  initial begin
    reset        = 1'b0;
    ps2_clock    = 1'b1;
    ps2_data     = 1'b1;
    held_errors  = 0;
    pulse_errors = 0;
    cycle_count  = 0;
    model_held   = '0;
    model_ext    = 1'b0;
    model_brk    = 1'b0;
    for (int k = 0; k < `KEY_COUNT; k++) begin
      pulse_count[k] = 0;
    end
    void'($urandom(32'h21cba08e));
    fill_table();
    cycle_limit = cycle_budget();
    repeat (16) @(negedge clock);
    reset = 1'b1;
    for (int r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("errors: %0d held, %0d pulse", held_errors, pulse_errors);
    if (held_errors == 0 && pulse_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tests/ps2_key_tracker_properties.sv
// concurrent checks on the key tracker outputs, attached with bind
// sampled on the rising system clock
// the output checks are quiet while reset is low
`timescale 1ns/1ps

module ps2_key_tracker_properties (
  input logic                     clock,
  input logic                     reset,
  input ps2_key_pkg::key_vector_t held,
  input ps2_key_pkg::key_vector_t pressed
);

  // a key can only pulse while it is down
  property pressed_within_held;
    @(posedge clock) disable iff (!reset)
      (pressed & ~held) == '0;
  endproperty

  // every pulse lasts exactly one cycle
  property pressed_single_cycle;
    @(posedge clock) disable iff (!reset)
      (pressed & $past(pressed)) == '0;
  endproperty

  // synchronous reset clears both vectors on the next edge
  property cleared_after_reset;
    @(posedge clock)
      !reset |=> (held == '0) && (pressed == '0);
  endproperty

  assert property (pressed_within_held)
    else $error("pressed bit set for a key that is not held");

  assert property (pressed_single_cycle)
    else $error("pressed bit high for two cycles in a row");

  assert property (cleared_after_reset)
    else $error("held or pressed not cleared after reset");

endmodule

bind ps2_key_tracker ps2_key_tracker_properties properties_i (
  .clock   (clock),
  .reset   (reset),
  .held    (held),
  .pressed (pressed)
);

// File: hdl/ps2_key_tracker.sv
// PS/2 keyboard tracker for twelve letter keys, scan code set 2
// receive only, the host never drives the keyboard lines
// held is high while a key is down, pressed pulses one cycle on key down
// held and pressed follow a stop bit's falling clock edge by 6 cycles
// print screen, pause and all E0 keys are ignored
// reset with keys down clears held until the keyboard repeats a make
`timescale 1ns/1ps

module ps2_key_tracker (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ps2_clock,
  input  logic                     ps2_data,
  output ps2_key_pkg::key_vector_t held,
  output ps2_key_pkg::key_vector_t pressed
);

  import ps2_key_pkg::*;

  // checked byte from the line receiver
  ps2_byte_t  rx_byte;
  // make or break event after prefix decoding
  key_event_t key_event;

  // serial frames to bytes, 4 cycles
  ps2_frame_receiver receiver_i (
    .clock     (clock),
    .reset     (reset),
    .ps2_clock (ps2_clock),
    .ps2_data  (ps2_data),
    .rx_byte   (rx_byte)
  );

  // bytes to events, 1 cycle
  scan_code_decoder decoder_i (
    .clock     (clock),
    .reset     (reset),
    .rx_byte   (rx_byte),
    .key_event (key_event)
  );

  // events to key vectors, 1 cycle
  key_state_tracker tracker_i (
    .clock     (clock),
    .reset     (reset),
    .key_event (key_event),
    .held      (held),
    .pressed   (pressed)
  );

endmodule

// File: hdl/key_state_tracker.sv
// held and pressed state of the twelve tracked letter keys
// held follows make and break events, pressed pulses on a 0 to 1 held change
// both update the cycle after the event strobe
// extended events and codes outside the table leave both untouched
// typematic repeats of a held key give no further pulse
`timescale 1ns/1ps
`include "ps2_key_settings.svh"

module key_state_tracker (
  input  logic                     clock,
  input  logic                     reset,
  input  ps2_key_pkg::key_event_t  key_event,
  output ps2_key_pkg::key_vector_t held,
  output ps2_key_pkg::key_vector_t pressed
);

  import ps2_key_pkg::*;

  // one-hot hit of the event code, zero for unknown codes
  key_vector_t match_vector;
  key_vector_t held_next;

  always_comb begin
    match_vector = '0;
    for (int i = 0; i < `KEY_COUNT; i++) begin
      if (key_event.code == key_code_of(key_index_t'(i))) begin
        match_vector[i] = 1'b1;
      end
    end
  end

  // next held state
  always_comb begin
    held_next = held;
    if (key_event.valid && !key_event.extended) begin
      if (key_event.make) begin
        held_next = held | match_vector;
      end else begin
        held_next = held & ~match_vector;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      held    <= '0;
      pressed <= '0;
    end else begin
      held    <= held_next;
      // rising bits only, a repeat make of a held key leaves this low
      pressed <= held_next & ~held;
    end
  end

endmodule

// File: hdl/scan_code_decoder.sv
// scan code set 2 prefix decoder
// E0 marks the next code extended, F0 marks it a break
// prefixes only move the state, any other byte yields one event
// event is valid the cycle after its byte, state returns to plain make
`timescale 1ns/1ps
`include "ps2_key_settings.svh"

module scan_code_decoder (
  input  logic                    clock,
  input  logic                    reset,
  input  ps2_key_pkg::ps2_byte_t  rx_byte,
  output ps2_key_pkg::key_event_t key_event
);

  import ps2_key_pkg::*;

  // bit 1 extended, bit 0 break
  typedef enum logic [1:0] {
    state_make           = 2'b00,
    state_break          = 2'b01,
    state_extended       = 2'b10,
    state_extended_break = 2'b11
  } decode_state_t;

  decode_state_t               decode_state;
  logic                        is_break;
  logic                        is_extended;
  logic                        event_valid;
  logic                        event_make;
  logic                        event_extended;
  logic [`PS2_DATA_BITS-1:0]   event_code;

  assign is_break    = (decode_state == state_break) || (decode_state == state_extended_break);
  assign is_extended = (decode_state == state_extended) ||
                       (decode_state == state_extended_break);

  // prefix FSM and event strobe
  always_ff @(posedge clock) begin
    if (!reset) begin
      decode_state <= state_make;
      event_valid  <= 1'b0;
    end else begin
      event_valid <= 1'b0;
      if (rx_byte.valid) begin
        case (rx_byte.data)
          code_prefix_extended: begin
            // keep a pending break
            decode_state <= is_break ? state_extended_break : state_extended;
          end
          code_prefix_break: begin
            // keep a pending extended
            decode_state <= is_extended ? state_extended_break : state_break;
          end
          default: begin
            event_valid  <= 1'b1;
            decode_state <= state_make;
          end
        endcase
      end
    end
  end

  // event fields, captured only for non-prefix bytes
  always_ff @(posedge clock) begin
    if (rx_byte.valid && rx_byte.data != code_prefix_extended &&
        rx_byte.data != code_prefix_break) begin
      event_make     <= !is_break;
      event_extended <= is_extended;
      event_code     <= rx_byte.data;
    end
  end

  assign key_event = '{
    valid:    event_valid,
    make:     event_make,
    extended: event_extended,
    code:     event_code
  };

endmodule

// File: hdl/ps2_frame_receiver.sv
// keyboard-to-host PS/2 frame receiver, receive only
// both lines are taken as plain inputs, host never drives them
// byte valid comes 4 system cycles after the stop bit's falling clock edge
// bad start, stop or parity drops the frame with no indication
// system clock must be well above the ps2 clock so each half bit spans cycles
`timescale 1ns/1ps
`include "ps2_key_settings.svh"

module ps2_frame_receiver (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ps2_clock,
  input  logic                   ps2_data,
  output ps2_key_pkg::ps2_byte_t rx_byte
);

  localparam int count_width = $clog2(`PS2_FRAME_BITS);
  localparam int idle_width  = $clog2(`PS2_IDLE_TIMEOUT);
  // position of the stop bit in the frame
  localparam logic [count_width-1:0] last_bit = count_width'(`PS2_FRAME_BITS - 1);
  localparam logic [idle_width-1:0]  idle_limit = idle_width'(`PS2_IDLE_TIMEOUT - 1);

  // two-flop synchronisers, bit 1 is the settled stage
  logic [1:0]                      clock_sync;
  logic [1:0]                      data_sync;
  logic                            clock_prev;
  // registered falling edge with its data sample
  logic                            fall_edge;
  logic                            data_bit;
  logic [count_width-1:0]          bit_count;
  // start, data and parity, start ends up in bit 0
  logic [`PS2_FRAME_BITS-2:0]      frame_shift;
  logic [idle_width-1:0]           idle_count;
  logic                            frame_ok;
  logic                            byte_valid;
  logic [`PS2_DATA_BITS-1:0]       byte_data;

  // lines idle high, so reset the chain high to avoid a false edge
  always_ff @(posedge clock) begin
    if (!reset) begin
      clock_sync <= 2'b11;
      data_sync  <= 2'b11;
      clock_prev <= 1'b1;
      fall_edge  <= 1'b0;
    end else begin
      clock_sync <= {clock_sync[0], ps2_clock};
      data_sync  <= {data_sync[0], ps2_data};
      clock_prev <= clock_sync[1];
      fall_edge  <= clock_prev & ~clock_sync[1];
    end
  end

  // start low, stop high, data plus parity has an odd count of ones
  // data_bit holds the stop bit while bit_count sits at last_bit
  assign frame_ok = !frame_shift[0] && data_bit && (^frame_shift[`PS2_FRAME_BITS-2:1]);

  // bit counter, idle watchdog and valid strobe
  always_ff @(posedge clock) begin
    if (!reset) begin
      bit_count  <= '0;
      idle_count <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (fall_edge) begin
        idle_count <= '0;
        if (bit_count == last_bit) begin
          bit_count  <= '0;
          byte_valid <= frame_ok;
        end else begin
          bit_count <= bit_count + 1'b1;
        end
      end else if (bit_count != '0) begin
        // mid frame with a silent clock
        if (idle_count == idle_limit) begin
          bit_count  <= '0;
          idle_count <= '0;
        end else begin
          idle_count <= idle_count + 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clock) begin
    data_bit <= data_sync[1];
    if (fall_edge) begin
      // lsb first, so shift in from the top
      frame_shift <= {data_bit, frame_shift[`PS2_FRAME_BITS-2:1]};
      if (bit_count == last_bit) begin
        byte_data <= frame_shift[`PS2_DATA_BITS:1];
      end
    end
  end

  assign rx_byte = '{valid: byte_valid, data: byte_data};

endmodule

// File: hdl/ps2_key_pkg.sv
// shared types and scan code set 2 constants for the PS/2 key tracker
// only single-byte make codes are listed, extended keys are not tracked
// key_code_of gives the code of each tracked key by its vector position
`include "ps2_key_settings.svh"

package ps2_key_pkg;

  // byte from the frame receiver, valid for one cycle
  typedef struct packed {
    logic                       valid;
    logic [`PS2_DATA_BITS-1:0]  data;
  } ps2_byte_t;

  // decoded key event, make low means break
  typedef struct packed {
    logic                       valid;
    logic                       make;
    logic                       extended;
    logic [`PS2_DATA_BITS-1:0]  code;
  } key_event_t;

  // bit position of each key in the held and pressed vectors
  typedef enum logic [3:0] {
    key_a = 4'd0,
    key_w,
    key_s,
    key_e,
    key_d,
    key_f,
    key_t,
    key_g,
    key_y,
    key_h,
    key_u,
    key_j = 4'd11
  } key_index_t;

  typedef logic [`KEY_COUNT-1:0] key_vector_t;

  // prefix bytes
  localparam logic [7:0] code_prefix_extended = 8'hE0;
  localparam logic [7:0] code_prefix_break    = 8'hF0;

  // make codes of the tracked keys
  localparam logic [7:0] code_key_a = 8'h1C;
  localparam logic [7:0] code_key_w = 8'h1D;
  localparam logic [7:0] code_key_s = 8'h1B;
  localparam logic [7:0] code_key_e = 8'h24;
  localparam logic [7:0] code_key_d = 8'h23;
  localparam logic [7:0] code_key_f = 8'h2B;
  localparam logic [7:0] code_key_t = 8'h2C;
  localparam logic [7:0] code_key_g = 8'h34;
  localparam logic [7:0] code_key_y = 8'h35;
  localparam logic [7:0] code_key_h = 8'h33;
  localparam logic [7:0] code_key_u = 8'h3C;
  localparam logic [7:0] code_key_j = 8'h3B;

  // lookup table, one entry per key position
  function automatic logic [7:0] key_code_of(key_index_t key);
    case (key)
      key_a:   return code_key_a;
      key_w:   return code_key_w;
      key_s:   return code_key_s;
      key_e:   return code_key_e;
      key_d:   return code_key_d;
      key_f:   return code_key_f;
      key_t:   return code_key_t;
      key_g:   return code_key_g;
      key_y:   return code_key_y;
      key_h:   return code_key_h;
      key_u:   return code_key_u;
      key_j:   return code_key_j;
      // F0 never reaches the tracker as an event code, so this never matches
      default: return code_prefix_break;
    endcase
  endfunction

endpackage

// File: hdl/ps2_key_settings.svh
// frame format, line timeout and key count for the PS/2 key tracker
// frame is start, eight data bits lsb first, odd parity, stop
// timeout counts system clock cycles, so retune it with the clock rate
// key count must agree with the key index enum in the package
`ifndef PS2_KEY_SETTINGS_SVH
`define PS2_KEY_SETTINGS_SVH

// bits in one keyboard-to-host frame
`define PS2_FRAME_BITS 11

// payload bits in one frame
`define PS2_DATA_BITS 8

// system cycles with no ps2 clock fall before a partial frame is dropped
// keyboards clock at 10 to 16.7 khz, so a bit period is far below this
`define PS2_IDLE_TIMEOUT 4096

// tracked letter keys
`define KEY_COUNT 12

`endif
